/* rvv_other_pkg.sv */
package rvv_other_pkg;

  // datapath geometry
  localparam int VLEN      = 128;
  localparam int XLEN      = 32;
  localparam int BYTE_W    = 8;
  localparam int HWORD_W   = 16;
  localparam int VLENB     = VLEN / BYTE_W;
  localparam int NUM_WORDS = VLEN / XLEN;

  typedef logic [VLEN-1:0] vreg_t;
  typedef logic [XLEN-1:0] xreg_t;
  typedef logic [3:0]      rob_tag_t;
  typedef logic [2:0]      uop_idx_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [5:0]      funct6_t;
  typedef logic [4:0]      vs1_code_t;
  typedef logic [1:0]      eew_t;

  // funct3 categories
  localparam funct3_t OPIVV = 3'b000;
  localparam funct3_t OPMVV = 3'b010;
  localparam funct3_t OPIVI = 3'b011;
  localparam funct3_t OPIVX = 3'b100;
  localparam funct3_t OPMVX = 3'b110;

  // funct6 groups handled by this lane
  localparam funct6_t VWXUNARY0    = 6'b010000;
  localparam funct6_t VXUNARY0     = 6'b010010;
  localparam funct6_t VMERGE_VMV   = 6'b010111;
  localparam funct6_t VSMUL_VMVNRR = 6'b100111;

  // vs1 field sub-opcodes
  localparam vs1_code_t VMV_X_S   = 5'b00000;
  localparam vs1_code_t VZEXT_VF4 = 5'b00100;
  localparam vs1_code_t VSEXT_VF4 = 5'b00101;
  localparam vs1_code_t VZEXT_VF2 = 5'b00110;
  localparam vs1_code_t VSEXT_VF2 = 5'b00111;

  localparam eew_t EEW8  = 2'b00;
  localparam eew_t EEW16 = 2'b01;
  localparam eew_t EEW32 = 2'b10;

  // result source picked by the decoder
  typedef logic [2:0] op_sel_t;

  localparam op_sel_t OP_NONE   = 3'd0;
  localparam op_sel_t OP_MOVE   = 3'd1;
  localparam op_sel_t OP_MERGE  = 3'd2;
  localparam op_sel_t OP_WHOLE  = 3'd3;
  localparam op_sel_t OP_EXTEND = 3'd4;

  // extension unit function
  typedef logic [2:0] ext_sel_t;

  localparam ext_sel_t EXT_ZVF2  = 3'd0;
  localparam ext_sel_t EXT_SVF2  = 3'd1;
  localparam ext_sel_t EXT_ZVF4  = 3'd2;
  localparam ext_sel_t EXT_SVF4  = 3'd3;
  localparam ext_sel_t EXT_ELEM0 = 3'd4;

endpackage

/* rvv_other_decode.sv */
`timescale 1ns/1ps

module rvv_other_decode (
  input  logic                     uop_valid,
  input  rvv_other_pkg::funct3_t   funct3,
  input  rvv_other_pkg::funct6_t   funct6,
  input  rvv_other_pkg::vs1_code_t vs1_code,
  input  logic                     vm,
  input  rvv_other_pkg::eew_t      vd_eew,
  input  rvv_other_pkg::eew_t      vs2_eew,
  input  logic                     v0_valid,
  input  logic                     vs1_valid,
  input  logic                     vs2_valid,
  input  logic                     rs1_valid,
  output logic                     fire,
  output rvv_other_pkg::op_sel_t   op_sel,
  output rvv_other_pkg::ext_sel_t  ext_sel,
  output logic                     src1_from_scalar,
  output rvv_other_pkg::eew_t      splat_eew,
  output logic                     splat_elem0
);
  import rvv_other_pkg::*;

  always_comb begin
    fire             = 1'b0;
    op_sel           = OP_NONE;
    ext_sel          = EXT_ELEM0;
    src1_from_scalar = 1'b0;
    splat_eew        = vd_eew;
    splat_elem0      = 1'b0;

    case (funct3)
      OPIVV, OPIVX, OPIVI: begin
        if (funct6 == VMERGE_VMV) begin
          // vm set means plain vmv.v, else vmerge
          src1_from_scalar = (funct3 != OPIVV);
          op_sel           = vm ? OP_MOVE : OP_MERGE;
          splat_eew        = vm ? vd_eew : vs2_eew;
          fire = uop_valid & (src1_from_scalar ? rs1_valid : vs1_valid)
                 & (vm | (vs2_valid & v0_valid));
        end else if (funct6 == VSMUL_VMVNRR && funct3 == OPIVI) begin
          op_sel = OP_WHOLE;
          fire   = uop_valid & vm & vs2_valid;
        end
      end
      OPMVV: begin
        if (funct6 == VXUNARY0) begin
          case (vs1_code)
            VZEXT_VF2, VSEXT_VF2: begin
              op_sel  = OP_EXTEND;
              ext_sel = (vs1_code == VZEXT_VF2) ? EXT_ZVF2 : EXT_SVF2;
              fire    = uop_valid & ~vs1_valid & vs2_valid
                        & ((vs2_eew == EEW8) | (vs2_eew == EEW16));
            end
            VZEXT_VF4, VSEXT_VF4: begin
              op_sel = OP_EXTEND;
              // quad widening only exists from bytes
              if (vs2_eew == EEW8) begin
                ext_sel = (vs1_code == VZEXT_VF4) ? EXT_ZVF4 : EXT_SVF4;
              end
              fire = uop_valid & ~vs1_valid & vs2_valid & (vs2_eew == EEW8);
            end
            default: ;
          endcase
        end else if (funct6 == VWXUNARY0 && vs1_code == VMV_X_S) begin
          op_sel = OP_EXTEND;
          fire   = uop_valid & vm & vs2_valid;
        end
      end
      OPMVX: begin
        if (funct6 == VWXUNARY0) begin
          // vmv.s.x writes element 0 only
          op_sel           = OP_MOVE;
          src1_from_scalar = 1'b1;
          splat_elem0      = 1'b1;
          fire             = uop_valid & vm & rs1_valid;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    if (fire && src1_from_scalar) begin
      assert (splat_eew inside {EEW8, EEW16, EEW32})
        else $error("scalar form fires with illegal element width %0d", splat_eew);
    end
  end

endmodule

/* rvv_scalar_splat.sv */
`timescale 1ns/1ps

module rvv_scalar_splat (
  input  rvv_other_pkg::xreg_t rs1_data,
  input  rvv_other_pkg::eew_t  splat_eew,
  input  logic                 splat_elem0,
  output rvv_other_pkg::vreg_t splat_data
);
  import rvv_other_pkg::*;

  // one word lane of the replicated scalar
  xreg_t lane;
  // element 0 alone, zero above
  xreg_t elem;

  always_comb begin
    case (splat_eew)
      EEW8: begin
        lane = {(XLEN/BYTE_W){rs1_data[BYTE_W-1:0]}};
        elem = xreg_t'(rs1_data[BYTE_W-1:0]);
      end
      EEW16: begin
        lane = {(XLEN/HWORD_W){rs1_data[HWORD_W-1:0]}};
        elem = xreg_t'(rs1_data[HWORD_W-1:0]);
      end
      EEW32: begin
        lane = rs1_data;
        elem = rs1_data;
      end
      default: begin
        lane = '0;
        elem = '0;
      end
    endcase
  end

  assign splat_data = splat_elem0 ? vreg_t'(elem) : {NUM_WORDS{lane}};

endmodule

/* rvv_elem_extend.sv */
`timescale 1ns/1ps

module rvv_elem_extend (
  input  rvv_other_pkg::vreg_t    vs2_data,
  input  rvv_other_pkg::eew_t     vs2_eew,
  input  rvv_other_pkg::uop_idx_t uop_index,
  input  rvv_other_pkg::ext_sel_t ext_sel,
  output rvv_other_pkg::vreg_t    ext_data
);
  import rvv_other_pkg::*;

  logic [VLEN/2-1:0] half;
  logic [VLEN/4-1:0] quarter;
  logic              sgn;

  // source slice for this micro-op of the group
  assign half    = vs2_data[uop_index[0]*(VLEN/2) +: VLEN/2];
  assign quarter = vs2_data[uop_index[1:0]*(VLEN/4) +: VLEN/4];
  assign sgn     = (ext_sel == EXT_SVF2) || (ext_sel == EXT_SVF4);

  always_comb begin
    ext_data = '0;
    case (ext_sel)
      EXT_ZVF2, EXT_SVF2: begin
        if (vs2_eew == EEW8) begin
          for (int i = 0; i < VLENB/2; i++) begin
            ext_data[i*HWORD_W +: HWORD_W] = {{BYTE_W{sgn & half[i*BYTE_W+BYTE_W-1]}},
                                              half[i*BYTE_W +: BYTE_W]};
          end
        end else if (vs2_eew == EEW16) begin
          for (int i = 0; i < NUM_WORDS; i++) begin
            ext_data[i*XLEN +: XLEN] = {{HWORD_W{sgn & half[i*HWORD_W+HWORD_W-1]}},
                                        half[i*HWORD_W +: HWORD_W]};
          end
        end
      end
      EXT_ZVF4, EXT_SVF4: begin
        for (int i = 0; i < NUM_WORDS; i++) begin
          ext_data[i*XLEN +: XLEN] = {{(XLEN-BYTE_W){sgn & quarter[i*BYTE_W+BYTE_W-1]}},
                                      quarter[i*BYTE_W +: BYTE_W]};
        end
      end
      EXT_ELEM0: begin
        // vmv.x.s, element width from vs2
        case (vs2_eew)
          EEW8:    ext_data[BYTE_W-1:0]  = vs2_data[BYTE_W-1:0];
          EEW16:   ext_data[HWORD_W-1:0] = vs2_data[HWORD_W-1:0];
          EEW32:   ext_data[XLEN-1:0]    = vs2_data[XLEN-1:0];
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    if (ext_sel == EXT_ZVF4 || ext_sel == EXT_SVF4) begin
      assert (vs2_eew == EEW8)
        else $error("vf4 extension selected with non-byte source");
    end
  end

endmodule

/* rvv_mask_merge.sv */
`timescale 1ns/1ps

module rvv_mask_merge (
  input  rvv_other_pkg::vreg_t    src1,
  input  rvv_other_pkg::vreg_t    src2,
  input  rvv_other_pkg::vreg_t    v0_data,
  input  rvv_other_pkg::eew_t     vs2_eew,
  input  rvv_other_pkg::uop_idx_t uop_index,
  output rvv_other_pkg::vreg_t    merge_data
);
  import rvv_other_pkg::*;

  // one mask bit per element of this micro-op
  logic [VLENB-1:0] mask;
  // mask bit spread over the bytes of its element
  logic [VLENB-1:0] byte_sel;

  always_comb begin
    case (vs2_eew)
      EEW8: begin
        mask = v0_data[uop_index*VLENB +: VLENB];
      end
      EEW16: begin
        mask = {{(VLENB/2){1'b0}}, v0_data[uop_index*(VLENB/2) +: VLENB/2]};
      end
      EEW32: begin
        mask = {{(VLENB*3/4){1'b0}}, v0_data[uop_index*(VLENB/4) +: VLENB/4]};
      end
      default: begin
        mask = '0;
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < VLENB; i++) begin
      case (vs2_eew)
        EEW16:   byte_sel[i] = mask[i/2];
        EEW32:   byte_sel[i] = mask[i/4];
        default: byte_sel[i] = mask[i];
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < VLENB; i++) begin
      merge_data[i*BYTE_W +: BYTE_W] = byte_sel[i] ? src1[i*BYTE_W +: BYTE_W]
                                                   : src2[i*BYTE_W +: BYTE_W];
    end
  end

  always_comb begin
    if (!$isunknown(vs2_eew)) begin
      assert (vs2_eew inside {EEW8, EEW16, EEW32})
        else $error("illegal vs2 element width code %0d", vs2_eew);
    end
  end

endmodule

/* rvv_alu_other.sv */
`timescale 1ns/1ps

module rvv_alu_other (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     uop_valid,
  input  rvv_other_pkg::rob_tag_t  rob_entry,
  input  rvv_other_pkg::funct3_t   funct3,
  input  rvv_other_pkg::funct6_t   funct6,
  input  rvv_other_pkg::vs1_code_t vs1_code,
  input  logic                     vm,
  input  rvv_other_pkg::eew_t      vd_eew,
  input  rvv_other_pkg::eew_t      vs2_eew,
  input  rvv_other_pkg::uop_idx_t  uop_index,
  input  rvv_other_pkg::vreg_t     v0_data,
  input  rvv_other_pkg::vreg_t     vs1_data,
  input  rvv_other_pkg::vreg_t     vs2_data,
  input  rvv_other_pkg::xreg_t     rs1_data,
  input  logic                     v0_valid,
  input  logic                     vs1_valid,
  input  logic                     vs2_valid,
  input  logic                     rs1_valid,
  output logic                     result_valid,
  output rvv_other_pkg::rob_tag_t  result_entry,
  output rvv_other_pkg::vreg_t     result_data
);
  import rvv_other_pkg::*;

  logic     fire;
  op_sel_t  op_sel;
  ext_sel_t ext_sel;
  logic     src1_from_scalar;
  eew_t     splat_eew;
  logic     splat_elem0;
  vreg_t    splat_data;
  vreg_t    src1;
  vreg_t    ext_data;
  vreg_t    merge_data;
  vreg_t    result_next;

  rvv_other_decode u_decode (
    .uop_valid        (uop_valid),
    .funct3           (funct3),
    .funct6           (funct6),
    .vs1_code         (vs1_code),
    .vm               (vm),
    .vd_eew           (vd_eew),
    .vs2_eew          (vs2_eew),
    .v0_valid         (v0_valid),
    .vs1_valid        (vs1_valid),
    .vs2_valid        (vs2_valid),
    .rs1_valid        (rs1_valid),
    .fire             (fire),
    .op_sel           (op_sel),
    .ext_sel          (ext_sel),
    .src1_from_scalar (src1_from_scalar),
    .splat_eew        (splat_eew),
    .splat_elem0      (splat_elem0)
  );

  rvv_scalar_splat u_splat (
    .rs1_data    (rs1_data),
    .splat_eew   (splat_eew),
    .splat_elem0 (splat_elem0),
    .splat_data  (splat_data)
  );

  // scalar and immediate forms take the replicated rs1
  assign src1 = src1_from_scalar ? splat_data : vs1_data;

  rvv_elem_extend u_extend (
    .vs2_data  (vs2_data),
    .vs2_eew   (vs2_eew),
    .uop_index (uop_index),
    .ext_sel   (ext_sel),
    .ext_data  (ext_data)
  );

  rvv_mask_merge u_merge (
    .src1       (src1),
    .src2       (vs2_data),
    .v0_data    (v0_data),
    .vs2_eew    (vs2_eew),
    .uop_index  (uop_index),
    .merge_data (merge_data)
  );

  always_comb begin
    case (op_sel)
      OP_MOVE:   result_next = src1;
      OP_MERGE:  result_next = merge_data;
      OP_WHOLE:  result_next = vs2_data;
      OP_EXTEND: result_next = ext_data;
      default:   result_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= fire;
    end
  end

  // payload to the ROB, held when nothing fires
  always_ff @(posedge clk) begin
    if (fire) begin
      result_entry <= rob_entry;
      result_data  <= result_next;
    end
  end

  // a result only ever follows an accepted micro-op
  assert property (@(posedge clk) disable iff (rst) result_valid |-> $past(uop_valid))
    else $error("result_valid without a micro-op in the previous cycle");

endmodule

/* tb_rvv_alu_other.sv */
`timescale 1ns/1ps

module tb_rvv_alu_other;
  import rvv_other_pkg::*;

  logic      clk;
  logic      rst;
  logic      uop_valid;
  rob_tag_t  rob_entry;
  funct3_t   funct3;
  funct6_t   funct6;
  vs1_code_t vs1_code;
  logic      vm;
  eew_t      vd_eew;
  eew_t      vs2_eew;
  uop_idx_t  uop_index;
  vreg_t     v0_data;
  vreg_t     vs1_data;
  vreg_t     vs2_data;
  xreg_t     rs1_data;
  logic      v0_valid;
  logic      vs1_valid;
  logic      vs2_valid;
  logic      rs1_valid;
  logic      result_valid;
  rob_tag_t  result_entry;
  vreg_t     result_data;

  int errors;
  int cycle_count;

  rvv_alu_other UUT (
    .clk          (clk),
    .rst          (rst),
    .uop_valid    (uop_valid),
    .rob_entry    (rob_entry),
    .funct3       (funct3),
    .funct6       (funct6),
    .vs1_code     (vs1_code),
    .vm           (vm),
    .vd_eew       (vd_eew),
    .vs2_eew      (vs2_eew),
    .uop_index    (uop_index),
    .v0_data      (v0_data),
    .vs1_data     (vs1_data),
    .vs2_data     (vs2_data),
    .rs1_data     (rs1_data),
    .v0_valid     (v0_valid),
    .vs1_valid    (vs1_valid),
    .vs2_valid    (vs2_valid),
    .rs1_valid    (rs1_valid),
    .result_valid (result_valid),
    .result_entry (result_entry),
    .result_data  (result_data)
  );

  always #4 clk = ~clk;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // global guard against a stuck run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > 2000) begin
      $display("run exceeded its cycle budget");
      abort_run();
    end
  end

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s valid expected %0b actual %0b", name, exp, act);
      errors++;
      abort_run();
    end
  endtask

  task automatic check_entry(input string name, input rob_tag_t exp, input rob_tag_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s entry expected %h actual %h", name, exp, act);
      errors++;
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input vreg_t exp, input vreg_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s data expected %h actual %h", name, exp, act);
      errors++;
      abort_run();
    end
  endtask

  task automatic clear_inputs();
    uop_valid = 1'b0;
    rob_entry = '0;
    funct3    = '0;
    funct6    = '0;
    vs1_code  = '0;
    vm        = 1'b0;
    vd_eew    = '0;
    vs2_eew   = '0;
    uop_index = '0;
    v0_data   = '0;
    vs1_data  = '0;
    vs2_data  = '0;
    rs1_data  = '0;
    v0_valid  = 1'b0;
    vs1_valid = 1'b0;
    vs2_valid = 1'b0;
    rs1_valid = 1'b0;
  endtask

  initial begin
    int    fd;
    int    code;
    int    n;
    int    gap;
    int    wait_count;
    string line;
    string name;
    logic  exp_valid;
    vreg_t exp_data;

    errors      = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    clear_inputs();
    void'($urandom(32'he51c28d1));

    fd = $fopen("golden_rvv_alu_other.txt", "r");
    if (fd == 0) begin
      $display("cannot open golden_rvv_alu_other.txt");
      abort_run();
    end

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    wait_count = 0;
    while ($isunknown(result_valid)) begin
      if (wait_count >= 10) begin
        $display("result_valid stayed unknown after reset");
        abort_run();
      end
      @(posedge clk);
      #1;
      wait_count++;
    end
    check_valid("after_reset", 1'b0, result_valid);

    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  name, funct3, funct6, vs1_code, vm, vd_eew, vs2_eew, uop_index,
                  rob_entry, v0_valid, vs1_valid, vs2_valid, rs1_valid, rs1_data,
                  v0_data, vs1_data, vs2_data, exp_valid, exp_data);
      if (n != 19) begin
        $display("malformed golden line: %s", line);
        abort_run();
      end
      uop_valid = 1'b1;

      // fixed one-cycle latency
      @(posedge clk);
      #1;
      check_valid(name, exp_valid, result_valid);
      if (exp_valid) begin
        check_entry(name, rob_entry, result_entry);
        check_data(name, exp_data, result_data);
      end

      gap = $urandom % 3;
      if (gap > 0) begin
        uop_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
          check_valid("idle", 1'b0, result_valid);
        end
      end
    end
    $fclose(fd);

    uop_valid = 1'b0;
    @(posedge clk);
    #1;
    check_valid("drain", 1'b0, result_valid);

    if (errors == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "errors were found");
    end
  end

endmodule

/* golden_rvv_alu_other.txt */
# name funct3 funct6 vs1_code vm vd_eew vs2_eew uop_index rob_entry v0_valid vs1_valid vs2_valid rs1_valid
# then rs1_data v0_data vs1_data vs2_data expected_valid expected_data, all in hex
vmv_vv_e8 0 17 00 1 0 0 0 0 0 1 0 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 0f0e0d0c0b0a09080706050403020100
vmv_vv_e16 0 17 00 1 1 1 0 1 0 1 0 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 0f0e0d0c0b0a09080706050403020100
vmv_vv_e32 0 17 00 1 2 2 0 2 0 1 0 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 0f0e0d0c0b0a09080706050403020100
vmv_vx_e8 4 17 00 1 0 0 0 3 0 0 0 1 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 78787878787878787878787878787878
vmv_vx_e16 4 17 00 1 1 1 0 4 0 0 0 1 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 56785678567856785678567856785678
vmv_vx_e32 4 17 00 1 2 2 0 5 0 0 0 1 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 12345678123456781234567812345678
vmv_vi_e8 3 17 00 1 0 0 0 6 0 0 0 1 fffffff5 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5
vmv_vi_e16 3 17 00 1 1 1 0 7 0 0 0 1 fffffff5 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 fff5fff5fff5fff5fff5fff5fff5fff5
vmv_vi_e32 3 17 00 1 2 2 0 8 0 0 0 1 fffffff5 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 fffffff5fffffff5fffffff5fffffff5
mrg_vv_e8_i0 0 17 00 0 0 0 0 9 1 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 f0e0d0c0b0a090800760054030021000
mrg_vv_e8_i1 0 17 00 0 0 0 1 a 1 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 0f0e0d0cb0a090807060504003020100
mrg_vv_e16_i2 0 17 00 0 1 1 2 b 1 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 f0e0d0c0b0a090800706050403020100
mrg_vv_e16_i3 0 17 00 0 1 1 3 c 1 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 0f0e0d0c0b0a09087060504030201000
mrg_vv_e32_i0 0 17 00 0 2 2 0 d 1 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 f0e0d0c00b0a09087060504003020100
mrg_vv_e32_i1 0 17 00 0 2 2 1 e 1 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 0f0e0d0cb0a090800706050430201000
mrg_vx_e8_i0 4 17 00 0 0 0 0 f 1 0 1 1 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 f0e0d0c0b0a090807860784030781078
mrg_vi_e32_i0 3 17 00 0 2 2 0 0 1 0 1 1 fffffff5 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 f0e0d0c0fffffff570605040fffffff5
ext_zvf2_e8_i0 2 12 06 1 1 0 0 1 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00700060005000400030002000100000
ext_svf2_e8_i1 2 12 07 1 1 0 1 2 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 fff0ffe0ffd0ffc0ffb0ffa0ff90ff80
ext_zvf2_e8_i1 2 12 06 1 1 0 1 3 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00f000e000d000c000b000a000900080
ext_svf2_e16_i1 2 12 07 1 2 1 1 4 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 fffff0e0ffffd0c0ffffb0a0ffff9080
ext_svf2_e16_i0 2 12 07 1 2 1 0 5 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00007060000050400000302000001000
ext_zvf4_e8_i2 2 12 04 1 2 0 2 6 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 000000b0000000a00000009000000080
ext_svf4_e8_i3 2 12 05 1 2 0 3 7 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 fffffff0ffffffe0ffffffd0ffffffc0
ext_svf4_e8_i1 2 12 05 1 2 0 1 8 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00000070000000600000005000000040
vmv_x_s_e32 2 10 00 1 2 2 0 9 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00000000000000000000000030201000
vmv_x_s_e16 2 10 00 1 1 1 0 a 0 0 1 0 00000000 000000000000000000000000f00f00a5 f0e0d0c0b0a090807060504030201000 0f0e0d0c0b0a09080706050403020100 1 00000000000000000000000000000100
vmv_s_x_e8 6 10 00 1 0 0 0 b 0 0 0 1 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00000000000000000000000000000078
vmv_s_x_e16 6 10 00 1 1 1 0 c 0 0 0 1 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00000000000000000000000000005678
vmv_s_x_e32 6 10 00 1 2 2 0 d 0 0 0 1 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 00000000000000000000000012345678
vmv_whole 3 27 00 1 0 0 0 e 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 f0e0d0c0b0a090807060504030201000
neg_mrg_no_v0 0 17 00 0 0 0 0 f 0 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 0 00000000000000000000000000000000
neg_vx_no_rs1 4 17 00 1 0 0 0 0 0 0 0 0 12345678 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 0 00000000000000000000000000000000
neg_vf4_e16 2 12 04 1 2 1 0 1 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 0 00000000000000000000000000000000
pos_after_neg 0 17 00 1 0 0 0 2 0 1 0 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 1 0f0e0d0c0b0a09080706050403020100
neg_ext_vs1v 2 12 06 1 1 0 0 3 0 1 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 0 00000000000000000000000000000000
neg_bad_f6 0 3f 00 1 0 0 0 4 1 1 1 1 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 0 00000000000000000000000000000000
neg_whole_vm0 3 27 00 0 0 0 0 5 0 0 1 0 00000000 000000000000000000000000f00f00a5 0f0e0d0c0b0a09080706050403020100 f0e0d0c0b0a090807060504030201000 0 00000000000000000000000000000000

/* files.f */
rvv_other_pkg.sv
rvv_other_decode.sv
rvv_scalar_splat.sv
rvv_elem_extend.sv
rvv_mask_merge.sv
rvv_alu_other.sv
tb_rvv_alu_other.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator; a failing run exits non-zero
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_rvv_alu_other \
  -o sim_rvv_alu_other

./obj_dir/sim_rvv_alu_other
